/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All checks passed
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not finish cleanly, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+logic
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/instr_cache.sv
logic/line_fill_port.sv
logic/icache_top.sv
test/tb_clock_gen.sv
test/icache_assert.sv
test/icache_tb.sv

/* logic/bus_pkg.sv */
`include "icache_consts.svh"

package bus_pkg;

    // one instruction word, also used for addresses
    typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

    // full line, word 0 sits in the low bits
    typedef logic [`ICACHE_BLOCK_WORDS*`ICACHE_WORD_BITS-1:0] line_t;

endpackage

/* logic/cache_pkg.sv */
`include "icache_consts.svh"

package cache_pkg;

    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] set_idx_t;
    typedef logic [`ICACHE_OFFSET_BITS-1:0] word_off_t;

    // entry layout is {recent, valid, tag}
    typedef logic [`ICACHE_TAG_BITS+1:0] tag_entry_t;

    // cache controller states
    typedef enum logic {
        CHECK,
        ALLOCATE
    } fill_state_t;

endpackage

/* logic/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// instruction word and address width
`define ICACHE_WORD_BITS 16

// words per cache line
`define ICACHE_BLOCK_WORDS 4

// address split, tag | index | offset
`define ICACHE_OFFSET_BITS 2
`define ICACHE_INDEX_BITS 1
`define ICACHE_TAG_BITS 13

// sets per way
`define ICACHE_SETS 2

`endif

/* logic/icache_data_store.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_data_store (
    input  logic                clk,
    input  cache_pkg::set_idx_t index,
    input  logic                write_en_way1,
    input  logic                write_en_way2,
    input  bus_pkg::line_t      write_line,
    output bus_pkg::line_t      read_way1,
    output bus_pkg::line_t      read_way2
);

    import bus_pkg::*;

    line_t way1_mem [`ICACHE_SETS];
    line_t way2_mem [`ICACHE_SETS];

    assign read_way1 = way1_mem[index];
    assign read_way2 = way2_mem[index];

    // only the victim way takes the fetched line
    always_ff @(posedge clk) begin
        if (write_en_way1) begin
            way1_mem[index] <= write_line;
        end
        if (write_en_way2) begin
            way2_mem[index] <= write_line;
        end
    end

endmodule

/* logic/icache_tag_store.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_tag_store (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cache_pkg::set_idx_t   index,
    input  logic                  write_en,
    input  cache_pkg::tag_entry_t write_way1,
    input  cache_pkg::tag_entry_t write_way2,
    output cache_pkg::tag_entry_t read_way1,
    output cache_pkg::tag_entry_t read_way2
);

    import cache_pkg::*;

    tag_entry_t way1_mem [`ICACHE_SETS];
    tag_entry_t way2_mem [`ICACHE_SETS];

    // read is combinational so the hit check fits in one cycle
    assign read_way1 = way1_mem[index];
    assign read_way2 = way2_mem[index];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // clears valid and recent bits of every set
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                way1_mem[i] <= '0;
                way2_mem[i] <= '0;
            end
        end else if (write_en) begin
            // both ways written together, recent bits move as a pair
            way1_mem[index] <= write_way1;
            way2_mem[index] <= write_way2;
        end
    end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/100ps

module icache_top (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           cpu_valid,
    input  bus_pkg::word_t cpu_addr,
    output logic           cpu_ready,
    output bus_pkg::word_t cpu_data,
    output logic           mem_req,
    output bus_pkg::word_t mem_addr,
    input  logic           mem_ack,
    input  bus_pkg::line_t mem_line
);

    import bus_pkg::*;

    // cache to fill port
    logic  fill_start;
    word_t fill_addr;
    logic  fill_done;
    line_t fill_line;

    instr_cache u_cache (
        .clk        (clk),
        .reset_n    (reset_n),
        .cpu_valid  (cpu_valid),
        .cpu_addr   (cpu_addr),
        .cpu_ready  (cpu_ready),
        .cpu_data   (cpu_data),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_line  (fill_line)
    );

    line_fill_port u_fill_port (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_line   (mem_line)
    );

endmodule

/* logic/instr_cache.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module instr_cache (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           cpu_valid,
    input  bus_pkg::word_t cpu_addr,
    output logic           cpu_ready,
    output bus_pkg::word_t cpu_data,
    output logic           fill_start,
    output bus_pkg::word_t fill_addr,
    input  logic           fill_done,
    input  bus_pkg::line_t fill_line
);

    import bus_pkg::*;
    import cache_pkg::*;

    fill_state_t state;
    fill_state_t state_next;

    tag_t      addr_tag;
    set_idx_t  addr_index;
    word_off_t addr_off;

    tag_entry_t tag_rd_way1;
    tag_entry_t tag_rd_way2;
    tag_entry_t tag_wr_way1;
    tag_entry_t tag_wr_way2;
    logic       tag_we;

    line_t line_rd_way1;
    line_t line_rd_way2;
    logic  line_we_way1;
    logic  line_we_way2;

    tag_t way1_tag;
    tag_t way2_tag;
    logic way1_valid;
    logic way2_valid;
    logic way1_recent;
    logic way2_recent;

    logic  hit_way1;
    logic  hit_way2;
    logic  cache_hit;
    logic  victim_way2;
    logic  victim_way2_q;
    word_t word_way1;
    word_t word_way2;

    assign addr_tag   = cpu_addr[`ICACHE_WORD_BITS-1 -: `ICACHE_TAG_BITS];
    assign addr_index = cpu_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign addr_off   = cpu_addr[`ICACHE_OFFSET_BITS-1:0];

    assign {way1_recent, way1_valid, way1_tag} = tag_rd_way1;
    assign {way2_recent, way2_valid, way2_tag} = tag_rd_way2;

    assign hit_way1  = way1_valid && (way1_tag == addr_tag);
    assign hit_way2  = way2_valid && (way2_tag == addr_tag);
    assign cache_hit = hit_way1 || hit_way2;

    // way 1 unless way 1 was the last one used
    assign victim_way2 = way1_recent;

    assign word_way1 = line_rd_way1[addr_off*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];
    assign word_way2 = line_rd_way2[addr_off*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];
    assign cpu_data  = hit_way1 ? word_way1 : word_way2;

    // line base for the fill
    assign fill_addr = {cpu_addr[`ICACHE_WORD_BITS-1:`ICACHE_OFFSET_BITS],
                        {`ICACHE_OFFSET_BITS{1'b0}}};

    always_comb begin
        state_next   = state;
        cpu_ready    = 1'b0;
        fill_start   = 1'b0;
        tag_we       = 1'b0;
        tag_wr_way1  = tag_rd_way1;
        tag_wr_way2  = tag_rd_way2;
        line_we_way1 = 1'b0;
        line_we_way2 = 1'b0;
        case (state)
            CHECK: begin
                if (cpu_valid) begin
                    tag_we = 1'b1;
                    if (cache_hit) begin
                        // zero-latency hit, just move the recent bit
                        cpu_ready   = 1'b1;
                        tag_wr_way1 = {hit_way1, way1_valid, way1_tag};
                        tag_wr_way2 = {!hit_way1, way2_valid, way2_tag};
                    end else begin
                        // new tag goes in now, data follows on fill_done
                        fill_start = 1'b1;
                        state_next = ALLOCATE;
                        if (victim_way2) begin
                            tag_wr_way1 = {1'b0, way1_valid, way1_tag};
                            tag_wr_way2 = {1'b1, 1'b1, addr_tag};
                        end else begin
                            tag_wr_way1 = {1'b1, 1'b1, addr_tag};
                            tag_wr_way2 = {1'b0, way2_valid, way2_tag};
                        end
                    end
                end
            end
            ALLOCATE: begin
                if (fill_done) begin
                    line_we_way1 = !victim_way2_q;
                    line_we_way2 = victim_way2_q;
                    state_next   = CHECK;
                end
            end
            default: state_next = CHECK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state         <= CHECK;
            victim_way2_q <= 1'b0;
        end else begin
            state <= state_next;
            // recent bits change at the miss edge, so keep the choice
            if (fill_start) begin
                victim_way2_q <= victim_way2;
            end
        end
    end

    icache_tag_store u_tag_store (
        .clk        (clk),
        .reset_n    (reset_n),
        .index      (addr_index),
        .write_en   (tag_we),
        .write_way1 (tag_wr_way1),
        .write_way2 (tag_wr_way2),
        .read_way1  (tag_rd_way1),
        .read_way2  (tag_rd_way2)
    );

    icache_data_store u_data_store (
        .clk           (clk),
        .index         (addr_index),
        .write_en_way1 (line_we_way1),
        .write_en_way2 (line_we_way2),
        .write_line    (fill_line),
        .read_way1     (line_rd_way1),
        .read_way2     (line_rd_way2)
    );

endmodule

/* logic/line_fill_port.sv */
`timescale 1ns/100ps

module line_fill_port (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           fill_start,
    input  bus_pkg::word_t fill_addr,
    output logic           fill_done,
    output bus_pkg::line_t fill_line,
    output logic           mem_req,
    output bus_pkg::word_t mem_addr,
    input  logic           mem_ack,
    input  bus_pkg::line_t mem_line
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_RELEASE
    } port_state_t;

    port_state_t state;
    word_t       addr_q;
    line_t       line_q;

    assign mem_req   = (state == FILL_REQ);
    assign mem_addr  = addr_q;
    assign fill_line = line_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= FILL_IDLE;
            fill_done <= 1'b0;
        end else begin
            // done pulse once memory has let go of ack
            fill_done <= (state == FILL_RELEASE) && !mem_ack;
            case (state)
                FILL_IDLE:    if (fill_start) state <= FILL_REQ;
                FILL_REQ:     if (mem_ack) state <= FILL_RELEASE;
                FILL_RELEASE: if (!mem_ack) state <= FILL_IDLE;
                default:      state <= FILL_IDLE;
            endcase
        end
    end

    // address and line payload
    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && fill_start) begin
            addr_q <= fill_addr;
        end
        if (state == FILL_REQ && mem_ack) begin
            line_q <= mem_line;
        end
    end

endmodule

/* test/icache_assert.sv */
`timescale 1ns/100ps

module icache_assert (
    input logic clk,
    input logic reset_n,
    input logic cpu_valid,
    input logic cpu_ready,
    input logic fill_start,
    input logic mem_req,
    input logic mem_ack
);

    // req may only fall after ack
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_req && !mem_ack |=> mem_req
    ) else $error("mem_req dropped before mem_ack was seen");

    // no answer to the cpu while the memory handshake is open
    ready_needs_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        cpu_ready |-> cpu_valid && !mem_req && !mem_ack
    ) else $error("cpu_ready high without cpu_valid or during a memory fill");

    // single cycle pulse toward the fill port
    fill_start_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_start |=> !fill_start
    ) else $error("fill_start held longer than one cycle");

endmodule

/* test/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb;

    import bus_pkg::*;

    localparam int    reset_cycles = 5;
    localparam int    read_timeout = 100;
    localparam int    sample_delay = 2;
    localparam word_t word_key     = 16'hA5C3;

    logic  clk;
    logic  reset_n;
    logic  cpu_valid;
    word_t cpu_addr;
    logic  cpu_ready;
    word_t cpu_data;
    logic  mem_req;
    word_t mem_addr;
    logic  mem_ack;
    line_t mem_line;

    int checks = 0;
    int errors = 0;
    int fill_count = 0;
    int mem_delay = 2;
    int wait_cnt;
    int last_latency;
    int seed = 59990;
    word_t exp_mem_addr = '0;

    // reference model indexed [set][way] with way 0 as way 1
    logic [12:0] model_tag    [2][2];
    logic        model_valid  [2][2];
    logic        model_recent [2][2];

    tb_clock_gen u_clock (.clk(clk));

    icache_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpu_valid (cpu_valid),
        .cpu_addr  (cpu_addr),
        .cpu_ready (cpu_ready),
        .cpu_data  (cpu_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_line  (mem_line)
    );

    bind icache_top icache_assert u_assert (
        .clk        (clk),
        .reset_n    (reset_n),
        .cpu_valid  (cpu_valid),
        .cpu_ready  (cpu_ready),
        .fill_start (fill_start),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack)
    );

    // memory word at address a is a ^ key
    function automatic line_t make_line(input word_t base);
        line_t words;
        for (int i = 0; i < 4; i++) begin
            words[i*16 +: 16] = (base + word_t'(i)) ^ word_key;
        end
        return words;
    endfunction

    // memory side of the four-phase handshake
    initial begin
        mem_ack = 1'b0;
        mem_line = '0;
        wait_cnt = 0;
        forever begin
            @(negedge clk);
            if (!reset_n) begin
                mem_ack = 1'b0;
                wait_cnt = 0;
            end else if (mem_req && !mem_ack) begin
                if (wait_cnt >= mem_delay) begin
                    check_value("mem_addr", mem_addr, exp_mem_addr);
                    mem_line = make_line(mem_addr);
                    mem_ack = 1'b1;
                    fill_count++;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end else if (!mem_req && mem_ack) begin
                mem_ack = 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR t=%0t %s got=%h expected=%h", $time, name, got, expected);
        end
    endtask

    function automatic logic predict_miss(input word_t addr);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[addr[2]][w] && model_tag[addr[2]][w] == addr[15:3]) begin
                hit = 1'b1;
            end
        end
        return !hit;
    endfunction

    task automatic model_update(input word_t addr);
        int set_i;
        int way;
        set_i = int'(addr[2]);
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[set_i][w] && model_tag[set_i][w] == addr[15:3]) begin
                way = w;
            end
        end
        if (way < 0) begin
            // way 1 when neither is recent, else the one not recent
            if (!model_recent[set_i][0] && !model_recent[set_i][1]) begin
                way = 0;
            end else if (model_recent[set_i][0]) begin
                way = 1;
            end else begin
                way = 0;
            end
            model_tag[set_i][way] = addr[15:3];
            model_valid[set_i][way] = 1'b1;
        end
        model_recent[set_i][way] = 1'b1;
        model_recent[set_i][1-way] = 1'b0;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic cpu_read(input word_t addr, output word_t data, output int cycles,
                            output bit done);
        done = 1'b0;
        data = '0;
        cycles = 0;
        cpu_valid = 1'b1;
        cpu_addr = addr;
        while (!done && cycles < read_timeout) begin
            #sample_delay;
            if (cpu_ready) begin
                data = cpu_data;
                done = 1'b1;
                if (mem_req || mem_ack) begin
                    errors++;
                    $display("cpu_ready rose while the memory handshake for %h was open", addr);
                end
            end
            @(negedge clk);
            cycles++;
        end
        cpu_valid = 1'b0;
        if (!done) begin
            errors++;
            $display("timed out after %0d cycles waiting for cpu_ready, address %h",
                     cycles, addr);
        end
    endtask

    task automatic read_check(input word_t addr, input int exp_fills);
        word_t data;
        int    cycles;
        bit    done;
        int    fills_before;
        fills_before = fill_count;
        // any fill must ask for the line base
        exp_mem_addr = {addr[15:2], 2'b00};
        cpu_read(addr, data, cycles, done);
        if (done) begin
            check_value($sformatf("cpu_data @%h", addr), data, addr ^ word_key);
            check_value($sformatf("fill count @%h", addr),
                        word_t'(fill_count - fills_before), word_t'(exp_fills));
        end
        model_update(addr);
        last_latency = cycles;
    endtask

    task automatic cold_miss();
        // tag 2, set 0, offset 2
        read_check(16'h0012, 1);
    endtask

    task automatic same_line_hits();
        read_check(16'h0010, 0);
        read_check(16'h0011, 0);
        read_check(16'h0013, 0);
    endtask

    task automatic two_tags_one_set();
        read_check(16'h0024, 1);
        read_check(16'h0034, 1);
        read_check(16'h0025, 0);
        read_check(16'h0036, 0);
    endtask

    task automatic lru_eviction();
        // A, B and C all land in set 0
        read_check(16'h0040, 1);
        read_check(16'h0050, 1);
        read_check(16'h0040, 0);
        read_check(16'h0060, 1);
        read_check(16'h0040, 0);
        read_check(16'h0050, 1);
    endtask

    task automatic slow_memory();
        mem_delay = 20;
        read_check(16'h0089, 1);
        check_value("cpu_ready latency above ack delay",
                    word_t'(last_latency > mem_delay), 16'h0001);
        mem_delay = 2;
    endtask

    task automatic random_reads();
        int    rnd;
        word_t addr;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            addr = 16'h0100 + word_t'(rnd[5:0]);
            read_check(addr, int'(predict_miss(addr)));
        end
    endtask

    initial begin
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        cpu_addr = '0;
        for (int s = 0; s < 2; s++) begin
            for (int w = 0; w < 2; w++) begin
                model_tag[s][w] = '0;
                model_valid[s][w] = 1'b0;
                model_recent[s][w] = 1'b0;
            end
        end
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("cpu_ready after reset", word_t'(cpu_ready), 16'h0000);
        check_value("mem_req after reset", word_t'(mem_req), 16'h0000);

        cold_miss();
        same_line_hits();
        two_tags_one_set();
        lru_eviction();
        slow_memory();
        random_reads();

        $display("checks=%0d errors=%0d fills=%0d", checks, errors, fill_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int half_period = 4
) (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule
